/* vlog.f */
core_pkg.sv
ifu.sv
idu.sv
gpr.sv
dispatch.sv
exu.sv
cpu_top.sv
cpu_top_assertions.sv
tb_cpu_top.sv

/* Makefile */
# Verilator flow for the RV32I subset core testbench

TOP := tb_cpu_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee run.log
	@if grep -q "TEST FAILED" run.log; then exit 1; fi
	@grep -q "TEST OK" run.log

clean:
	rm -rf obj_dir run.log

/* tb_cpu_top.sv */
// tb_cpu_top: random program testbench comparing core write-backs against an ISA model
`default_nettype none
`timescale 1ns/1ps

module tb_cpu_top;

    localparam core_pkg::xlen_t RESET_VECTOR   = 32'h0000_1000;
    localparam int              CLK_PERIOD     = 8;
    localparam int              RESET_CYCLES   = 16;
    localparam int              MEM_WORDS      = 64;
    localparam int              TIMEOUT_NS     = (MEM_WORDS * 3 + RESET_CYCLES) * CLK_PERIOD + 400;
    localparam core_pkg::xlen_t SELF_JUMP_ADDR = RESET_VECTOR + 32'd252; // last word
    localparam logic [31:0]     LFSR_SEED      = 32'h39a140b7;
    localparam logic [31:0]     LFSR_TAPS      = 32'h80200003;
    // {funct7, funct3} of add, sub, and, or, xor, slt, sltu, add
    localparam logic [9:0] R_OPS [0:7] = '{10'h000, 10'h100, 10'h007, 10'h006,
                                           10'h004, 10'h002, 10'h003, 10'h000};
    localparam logic [2:0] I_F3 [0:3] = '{3'b000, 3'b111, 3'b110, 3'b100}; // addi andi ori xori

    logic                clk = 1'b0;
    logic                rst_n;
    core_pkg::xlen_t     imem_addr;
    core_pkg::inst_t     imem_data;
    core_pkg::wb_t       wb;
    core_pkg::xlen_t     word_offset;
    core_pkg::inst_t     imem [0:MEM_WORDS-1];
    core_pkg::wb_t       expect_q [$];
    core_pkg::wb_t       exp_wb;
    logic [31:0]         lfsr_q;
    int                  errors = 0;
    int                  write_count = 0;
    int                  total;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu_top #(.RESET_VECTOR(RESET_VECTOR)) dut (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .imem_addr_o(imem_addr),
        .imem_data_i(imem_data),
        .wb_o       (wb)
    );

    assign word_offset = (imem_addr - RESET_VECTOR) >> 2;
    assign imem_data   = imem[word_offset[5:0]]; // same-cycle instruction memory

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic core_pkg::inst_t r_type_word(input logic [9:0] f,
            input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs1,
            input core_pkg::reg_addr_t rs2);
        return {f[9:3], rs2, rs1, f[2:0], rd, core_pkg::OPC_OP};
    endfunction

    function automatic core_pkg::inst_t i_type_word(input logic [2:0] f3,
            input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs1,
            input logic [11:0] imm);
        return {imm, rs1, f3, rd, core_pkg::OPC_OP_IMM};
    endfunction

    function automatic core_pkg::inst_t branch_word(input logic is_bne,
            input core_pkg::reg_addr_t rs1, input core_pkg::reg_addr_t rs2,
            input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, is_bne, off[4:1], off[11],
                core_pkg::OPC_BRANCH};
    endfunction

    function automatic core_pkg::inst_t jal_word(input core_pkg::reg_addr_t rd,
            input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::OPC_JAL};
    endfunction

    // mostly alu ops with some forward branches and jumps of 8 or 12 bytes
    task automatic build_program();
        logic [3:0]          kind;
        logic [2:0]          op;
        core_pkg::reg_addr_t rd;
        core_pkg::reg_addr_t rs1;
        core_pkg::reg_addr_t rs2;
        logic [11:0]         imm;
        logic [19:0]         upper;
        for (int i = 0; i < MEM_WORDS - 1; i++) begin
            kind  = 4'(take_bits(4));
            op    = 3'(take_bits(3));
            rd    = core_pkg::reg_addr_t'(take_bits(3));
            rs1   = core_pkg::reg_addr_t'(take_bits(3));
            rs2   = core_pkg::reg_addr_t'(take_bits(3));
            imm   = 12'(take_bits(12));
            upper = 20'(take_bits(20));
            if (kind < 4'd7 || kind == 4'd15) begin
                imem[i] = r_type_word(R_OPS[op], rd, rs1, rs2);
            end else if (kind < 4'd11) begin
                imem[i] = i_type_word(I_F3[op[1:0]], rd, rs1, imm);
            end else if (kind == 4'd11) begin
                imem[i] = {upper, rd, core_pkg::OPC_LUI};
            end else if (i >= MEM_WORDS - 4) begin
                imem[i] = i_type_word(3'b000, rd, rs1, imm); // no room to jump forward
            end else if (kind < 4'd14) begin
                imem[i] = branch_word(op[0], rs1, rs2, op[1] ? 13'd12 : 13'd8);
            end else begin
                imem[i] = jal_word(rd, op[1] ? 21'd12 : 21'd8);
            end
        end
        imem[MEM_WORDS-1] = jal_word(5'd0, 21'd0); // park on itself
    endtask

    // in-order ISA model that queues every expected register write
    task automatic run_model();
        core_pkg::xlen_t regs [0:31];
        core_pkg::xlen_t pc;
        core_pkg::xlen_t next_pc;
        core_pkg::xlen_t off;
        core_pkg::xlen_t a;
        core_pkg::xlen_t b;
        core_pkg::xlen_t res;
        core_pkg::inst_t w;
        logic            writes;
        int              steps;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc    = RESET_VECTOR;
        steps = 0;
        while (pc != SELF_JUMP_ADDR && steps < 1000) begin
            off     = (pc - RESET_VECTOR) >> 2;
            w       = imem[off[5:0]];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            res     = '0;
            writes  = 1'b1;
            next_pc = pc + 32'd4;
            case (w[6:0])
                core_pkg::OPC_OP: begin
                    case ({w[31:25], w[14:12]})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h007: res = a & b;
                        10'h006: res = a | b;
                        10'h004: res = a ^ b;
                        10'h002: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        10'h003: res = (a < b) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                core_pkg::OPC_OP_IMM: begin
                    b = {{20{w[31]}}, w[31:20]};
                    case (w[14:12])
                        3'b000:  res = a + b;
                        3'b111:  res = a & b;
                        3'b110:  res = a | b;
                        3'b100:  res = a ^ b;
                        default: writes = 1'b0;
                    endcase
                end
                core_pkg::OPC_LUI: res = {w[31:12], 12'b0};
                core_pkg::OPC_BRANCH: begin
                    writes = 1'b0;
                    if (w[12] ? (a != b) : (a == b)) begin
                        next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                core_pkg::OPC_JAL: begin
                    res     = pc + 32'd4;
                    next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: writes = 1'b0;
            endcase
            if (writes && w[11:7] != 5'd0) begin // x0 stays zero
                regs[w[11:7]] = res;
                expect_q.push_back('{we: 1'b1, addr: w[11:7], data: res});
            end
            pc = next_pc;
            steps++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && wb.we) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("write-back to x%0d with %h when the model expects no more writes",
                         wb.addr, wb.data);
            end else begin
                exp_wb = expect_q.pop_front();
                write_count++;
                assert (wb == exp_wb) else begin
                    errors++;
                    $display("CHECK FAILED write-back %0d: expected x%0d = %h, actual x%0d = %h",
                             write_count, exp_wb.addr, exp_wb.data, wb.addr, wb.data);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out before the program reached its final self-jump");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n  <= 1'b0;
        lfsr_q = LFSR_SEED;
        build_program();
        run_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (!(expect_q.size() == 0 && imem_addr == SELF_JUMP_ADDR)) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // anything still in flight would show up here
        total = errors + int'(dut.u_assertions.fail_count);
        $display("summary: %0d write-backs checked, %0d check errors, %0d assertion failures",
                 write_count, errors, dut.u_assertions.fail_count);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu_top_assertions.sv */
// cpu_top_assertions: bound checker for reset, fetch alignment and flush behaviour of the core
`default_nettype none
`timescale 1ns/1ps

module cpu_top_assertions #(
    parameter core_pkg::xlen_t RESET_VECTOR = '0
) (
    input wire                  clk,
    input wire                  rst_n_i,
    input wire core_pkg::xlen_t imem_addr_i,
    input wire core_pkg::wb_t   wb_i
);

    int unsigned fail_count = 0; // failed assertions so far

    reset_quiet: assert property (@(posedge clk) !rst_n_i |-> !wb_i.we)
        else begin fail_count++; $error("write-back enabled while in reset"); end

    // first address after release
    first_fetch: assert property (@(posedge clk) $rose(rst_n_i) |-> imem_addr_i == RESET_VECTOR)
        else begin fail_count++; $error("first fetch address is not the reset vector"); end

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        imem_addr_i[1:0] == 2'b00)
        else begin fail_count++; $error("fetch address not word aligned"); end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i.we |-> wb_i.addr != '0)
        else begin fail_count++; $error("write-back targets x0"); end

    // both flushed slots stay silent after a redirect
    flush_first: assert property (@(posedge clk) disable iff (!rst_n_i)
        (imem_addr_i != $past(imem_addr_i) + 32'd4) |-> !wb_i.we)
        else begin fail_count++; $error("write-back in first cycle after redirect"); end

    flush_second: assert property (@(posedge clk) disable iff (!rst_n_i)
        (imem_addr_i != $past(imem_addr_i) + 32'd4) |=> !wb_i.we)
        else begin fail_count++; $error("write-back in second cycle after redirect"); end

endmodule

bind cpu_top cpu_top_assertions #(.RESET_VECTOR(RESET_VECTOR)) u_assertions (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .imem_addr_i(imem_addr_o),
    .wb_i       (wb_o)
);

`default_nettype wire

/* cpu_top.sv */
// cpu_top: three-stage RV32I subset core, fetch, decode and execute with write-back
`default_nettype none
`timescale 1ns/1ps

module cpu_top #(
    parameter core_pkg::xlen_t RESET_VECTOR = '0
) (
    input  wire                   clk,
    input  wire                   rst_n_i,
    output core_pkg::xlen_t       imem_addr_o,
    input  wire  core_pkg::inst_t imem_data_i,
    output core_pkg::wb_t         wb_o
);

    core_pkg::inst_t     fetch_inst;
    core_pkg::xlen_t     fetch_pc;
    logic                fetch_valid;
    core_pkg::dec_info_t dec;
    core_pkg::xlen_t     rs1_data;
    core_pkg::xlen_t     rs2_data;
    core_pkg::ex_req_t   ex_req;
    logic                jump;
    core_pkg::xlen_t     jump_addr;

    ifu #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_ifu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .jump_i      (jump),
        .jump_addr_i (jump_addr),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .inst_o      (fetch_inst),
        .inst_pc_o   (fetch_pc),
        .inst_valid_o(fetch_valid)
    );

    idu u_idu (
        .inst_i(fetch_inst),
        .dec_o (dec)
    );

    // reads come straight from the decoder fields, writes from exu
    gpr u_gpr (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs1_i     (dec.rs1),
        .rs2_i     (dec.rs2),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .wb_i      (wb_o)
    );

    dispatch u_dispatch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_valid_i(fetch_valid),
        .inst_pc_i   (fetch_pc),
        .dec_i       (dec),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .jump_i      (jump),
        .ex_o        (ex_req)
    );

    exu u_exu (
        .ex_i       (ex_req),
        .wb_o       (wb_o),
        .jump_o     (jump),
        .jump_addr_o(jump_addr)
    );

endmodule

`default_nettype wire

/* exu.sv */
// exu: ALU, branch compare and redirect, drives the register write-back
`default_nettype none
`timescale 1ns/1ps

module exu (
    input  wire  core_pkg::ex_req_t ex_i,
    output core_pkg::wb_t           wb_o,
    output logic                    jump_o,
    output core_pkg::xlen_t         jump_addr_o
);

    core_pkg::xlen_t alu_res;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            taken;

    assign lt_signed   = $signed(ex_i.op1) < $signed(ex_i.op2);
    assign lt_unsigned = ex_i.op1 < ex_i.op2;

    always_comb begin
        case (ex_i.alu_op)
            core_pkg::ALU_ADD: begin
                alu_res = ex_i.op1 + ex_i.op2;
            end
            core_pkg::ALU_SUB: begin
                alu_res = ex_i.op1 - ex_i.op2;
            end
            core_pkg::ALU_AND: begin
                alu_res = ex_i.op1 & ex_i.op2;
            end
            core_pkg::ALU_OR: begin
                alu_res = ex_i.op1 | ex_i.op2;
            end
            core_pkg::ALU_XOR: begin
                alu_res = ex_i.op1 ^ ex_i.op2;
            end
            core_pkg::ALU_SLT: begin
                alu_res = {{(core_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            core_pkg::ALU_SLTU: begin
                alu_res = {{(core_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            core_pkg::ALU_PASS_OP2: begin
                alu_res = ex_i.op2; // lui immediate
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // branch decision, op2 holds rs2 for beq/bne
    always_comb begin
        case (ex_i.branch)
            core_pkg::BR_BEQ: taken = (ex_i.op1 == ex_i.op2);
            core_pkg::BR_BNE: taken = (ex_i.op1 != ex_i.op2);
            core_pkg::BR_JAL: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    // single-cycle pulse, the execute register clears behind it
    assign jump_o      = ex_i.valid && taken;
    assign jump_addr_o = ex_i.target;

    always_comb begin
        wb_o.we   = ex_i.valid && ex_i.reg_we;
        wb_o.addr = ex_i.rd;
        if (ex_i.branch == core_pkg::BR_JAL) begin
            wb_o.data = ex_i.link_value; // return address
        end else begin
            wb_o.data = alu_res;
        end
    end

endmodule

`default_nettype wire

/* dispatch.sv */
// dispatch: decode-to-execute register with operand select and branch target adder
`default_nettype none
`timescale 1ns/1ps

module dispatch (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       inst_valid_i,
    input  wire  core_pkg::xlen_t     inst_pc_i,
    input  wire  core_pkg::dec_info_t dec_i,
    input  wire  core_pkg::xlen_t     rs1_data_i,
    input  wire  core_pkg::xlen_t     rs2_data_i,
    input  wire                       jump_i,
    output core_pkg::ex_req_t         ex_o
);

    core_pkg::xlen_t op2;
    core_pkg::xlen_t link;

    assign op2  = dec_i.use_imm ? dec_i.imm : rs2_data_i;
    // return address only carried by jal, zero otherwise
    assign link = dec_i.is_jal_link ? inst_pc_i + 32'd4 : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o <= '0;
        end else begin
            ex_o.valid      <= inst_valid_i && !jump_i; // flush on taken jump
            ex_o.alu_op     <= dec_i.alu_op;
            ex_o.branch     <= dec_i.branch;
            ex_o.op1        <= rs1_data_i;
            ex_o.op2        <= op2;
            ex_o.link_value <= link;
            ex_o.target     <= inst_pc_i + dec_i.imm;
            ex_o.reg_we     <= dec_i.reg_we;
            ex_o.rd         <= dec_i.rd;
        end
    end

endmodule

`default_nettype wire

/* gpr.sv */
// gpr: 31 general-purpose registers, x0 reads zero, write data bypassed to reads
`default_nettype none
`timescale 1ns/1ps

module gpr (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire  core_pkg::reg_addr_t rs1_i,
    input  wire  core_pkg::reg_addr_t rs2_i,
    output core_pkg::xlen_t           rs1_data_o,
    output core_pkg::xlen_t           rs2_data_o,
    input  wire  core_pkg::wb_t       wb_i
);

    core_pkg::xlen_t regs_q [1:31]; // no storage for x0

    // same-cycle write from exu wins over the array
    function automatic core_pkg::xlen_t read_port(input core_pkg::reg_addr_t addr);
        core_pkg::xlen_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wb_i.we && wb_i.addr == addr) begin
            data = wb_i.data;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.addr != '0) begin
            regs_q[wb_i.addr] <= wb_i.data;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

/* idu.sv */
// idu: combinational decoder for the kept RV32I subset, unknown encodings become no-ops
`default_nettype none
`timescale 1ns/1ps

module idu (
    input  wire  core_pkg::inst_t inst_i,
    output core_pkg::dec_info_t   dec_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    core_pkg::xlen_t imm_i;
    core_pkg::xlen_t imm_u;
    core_pkg::xlen_t imm_b;
    core_pkg::xlen_t imm_j;
    logic            writes_rd;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // immediate formats
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        dec_o        = '0;
        dec_o.alu_op = core_pkg::ALU_ADD;
        dec_o.branch = core_pkg::BR_NONE;
        dec_o.rd     = inst_i[11:7];
        dec_o.rs1    = inst_i[19:15];
        dec_o.rs2    = inst_i[24:20];
        writes_rd    = 1'b0;

        case (opcode)
            core_pkg::OPC_OP: begin
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_o.alu_op = core_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: dec_o.alu_op = core_pkg::ALU_SUB;
                    {7'b0000000, 3'b111}: dec_o.alu_op = core_pkg::ALU_AND;
                    {7'b0000000, 3'b110}: dec_o.alu_op = core_pkg::ALU_OR;
                    {7'b0000000, 3'b100}: dec_o.alu_op = core_pkg::ALU_XOR;
                    {7'b0000000, 3'b010}: dec_o.alu_op = core_pkg::ALU_SLT;
                    {7'b0000000, 3'b011}: dec_o.alu_op = core_pkg::ALU_SLTU;
                    default:              writes_rd    = 1'b0; // m-ext, shifts
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                writes_rd     = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_i;
                case (funct3)
                    3'b000:  dec_o.alu_op = core_pkg::ALU_ADD;
                    3'b111:  dec_o.alu_op = core_pkg::ALU_AND;
                    3'b110:  dec_o.alu_op = core_pkg::ALU_OR;
                    3'b100:  dec_o.alu_op = core_pkg::ALU_XOR;
                    default: writes_rd    = 1'b0;
                endcase
            end
            core_pkg::OPC_LUI: begin
                writes_rd     = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
                dec_o.alu_op  = core_pkg::ALU_PASS_OP2;
            end
            core_pkg::OPC_BRANCH: begin
                dec_o.imm = imm_b; // compare uses rs2, imm only feeds the target
                case (funct3)
                    3'b000:  dec_o.branch = core_pkg::BR_BEQ;
                    3'b001:  dec_o.branch = core_pkg::BR_BNE;
                    default: dec_o.branch = core_pkg::BR_NONE;
                endcase
            end
            core_pkg::OPC_JAL: begin
                writes_rd         = 1'b1;
                dec_o.imm         = imm_j;
                dec_o.branch      = core_pkg::BR_JAL;
                dec_o.is_jal_link = 1'b1;
            end
            default: ;
        endcase

        // x0 never gets written, later stages rely on this
        dec_o.reg_we = writes_rd && (dec_o.rd != '0);
    end

endmodule

`default_nettype wire

/* ifu.sv */
// ifu: program counter, instruction memory address and fetch register with valid bit
`default_nettype none
`timescale 1ns/1ps

module ifu #(
    parameter core_pkg::xlen_t RESET_VECTOR = '0
) (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   jump_i,
    input  wire  core_pkg::xlen_t jump_addr_i,
    output core_pkg::xlen_t       imem_addr_o,
    input  wire  core_pkg::inst_t imem_data_i,
    output core_pkg::inst_t       inst_o,
    output core_pkg::xlen_t       inst_pc_o,
    output logic                  inst_valid_o
);

    core_pkg::xlen_t pc_q;
    core_pkg::xlen_t pc_next;

    // redirect wins over the sequential step
    assign pc_next     = jump_i ? jump_addr_i : pc_q + 32'd4;
    assign imem_addr_o = pc_q; // memory answers in the same cycle

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_VECTOR;
        end else begin
            pc_q <= pc_next;
        end
    end

    // the word fetched in a jump cycle is on the wrong path
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= !jump_i;
        end
    end

    // fetched word and its address
    always_ff @(posedge clk) begin
        inst_o    <= imem_data_i;
        inst_pc_o <= pc_q;
    end

endmodule

`default_nettype wire

/* core_pkg.sv */
// core_pkg: shared widths, opcodes, operation codes and pipeline structs of the core
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;     // data or address word
    typedef logic [31:0]     inst_t;     // raw instruction word
    typedef logic [4:0]      reg_addr_t; // gpr index

    // major opcodes of the kept subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_OP2 // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL
    } branch_e;

    // decoder output
    typedef struct packed {
        alu_op_e   alu_op;
        branch_e   branch;
        logic      use_imm;     // op2 from imm instead of rs2
        logic      is_jal_link;
        logic      reg_we;      // already cleared for rd == x0
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
    } dec_info_t;

    // execute stage request
    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        branch_e   branch;
        xlen_t     op1;
        xlen_t     op2;
        xlen_t     link_value; // pc + 4
        xlen_t     target;     // pc + imm
        logic      reg_we;
        reg_addr_t rd;
    } ex_req_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        xlen_t     data;
    } wb_t;

endpackage

`default_nettype wire
